// ==== lsuPkg.sv ====
package lsuPkg;

    localparam int ADDR_W = 8;   // Word address
    localparam int DATA_W = 32;
    localparam int ID_W = 8;
    localparam int TAG_W = 2;    // Four reads in flight

    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [DATA_W-1:0] dataT;
    typedef logic [ID_W-1:0] opIdT;
    typedef logic [TAG_W-1:0] tagT;

    // Operation as it arrives in program order
    typedef struct packed {
        logic valid;
        logic isStore;
        addrT addr;
        dataT data;    // Only meaningful for stores
        opIdT opId;
    } memOpT;

    typedef struct packed {
        logic valid;
        addrT addr;
        opIdT opId;
        logic fwdHit;   // Store queue already holds the data
        dataT fwdData;
    } loadIssueT;

    typedef struct packed {
        logic valid;
        logic write;
        addrT addr;
        dataT data;
        tagT tag;
    } memReqT;

    // Read data coming back from memory
    typedef struct packed {
        logic valid;
        tagT tag;
        dataT data;
    } memResT;

    typedef struct packed {
        logic valid;
        opIdT opId;
        dataT data;
    } loadResultT;

endpackage

// ==== lsuFifo.sv ====
`timescale 1ns/1ps

module lsuFifo #(
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic reset,

    input lsuPkg::memOpT opIn,
    output logic opCredit,

    output lsuPkg::memOpT head,
    input logic pop
);
    import lsuPkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    memOpT entries [DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic doPush;
    logic doPop;

    // Pointers wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign doPush = opIn.valid && (count != CNT_W'(DEPTH));
    assign doPop = pop && (count != '0);
    assign opCredit = doPop;    // Each freed slot goes back to the sender

    always_comb begin
        head = entries[rdPtr];
        head.valid = (count != '0);
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= opIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + CNT_W'(doPush) - CNT_W'(doPop);
        end
    end

endmodule

// ==== storeQueue.sv ====
`timescale 1ns/1ps

module storeQueue #(
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic reset,

    input lsuPkg::memOpT head,
    output logic pop,

    input logic loadReady,
    output lsuPkg::loadIssueT loadIssue,

    output lsuPkg::memReqT stReq,
    input logic stGrant
);
    import lsuPkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry 0 is always the oldest store, younger ones sit above it
    addrT stAddr [DEPTH];
    dataT stData [DEPTH];
    logic [CNT_W-1:0] count;
    logic [PTR_W-1:0] wrIdx;
    logic pushSt;
    logic issueLd;
    logic drainSt;
    logic fwdHit;
    dataT fwdData;

    assign pushSt = head.valid && head.isStore && (count != CNT_W'(DEPTH));
    assign issueLd = head.valid && !head.isStore && loadReady;
    assign pop = pushSt || issueLd;
    assign drainSt = stGrant && (count != '0);

    // A drain in the same cycle shifts everything down by one slot
    assign wrIdx = PTR_W'(count - CNT_W'(drainSt));

    // Every store held here is older than the load at the head
    always_comb begin
        fwdHit = 1'b0;
        fwdData = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if ((CNT_W'(i) < count) && (stAddr[i] == head.addr)) begin
                fwdHit = 1'b1;
                fwdData = stData[i];    // Later entries are younger and override
            end
        end
    end

    always_comb begin
        loadIssue.valid = issueLd;
        loadIssue.addr = head.addr;
        loadIssue.opId = head.opId;
        loadIssue.fwdHit = fwdHit;
        loadIssue.fwdData = fwdData;
    end

    always_comb begin
        stReq.valid = (count != '0);
        stReq.write = 1'b1;
        stReq.addr = stAddr[0];
        stReq.data = stData[0];
        stReq.tag = '0;     // Writes get no response
    end

    always_ff @(posedge clk) begin
        if (drainSt) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                stAddr[i] <= stAddr[i + 1];
                stData[i] <= stData[i + 1];
            end
        end
        if (pushSt) begin
            stAddr[wrIdx] <= head.addr;
            stData[wrIdx] <= head.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(pushSt) - CNT_W'(drainSt);
        end
    end

endmodule

// ==== loadUnit.sv ====
`timescale 1ns/1ps

module loadUnit (
    input logic clk,
    input logic reset,

    input lsuPkg::loadIssueT loadIssue,
    output logic loadReady,

    output lsuPkg::memReqT ldReq,
    input logic ldGrant,

    input lsuPkg::memResT memRes,
    output lsuPkg::loadResultT loadResult
);
    import lsuPkg::*;

    localparam int NUM_TAGS = 1 << TAG_W;

    logic [NUM_TAGS-1:0] tagBusy;
    opIdT tagOpId [NUM_TAGS];
    logic anyFree;
    tagT freeTag;

    logic reqValid;
    addrT reqAddr;
    tagT reqTag;

    // Parks a memory response that lost the result slot to a forwarded load
    logic holdValid;
    opIdT holdOpId;
    dataT holdData;

    logic resValid;
    opIdT resOpId;
    dataT resData;

    logic fwdIssue;
    logic memIssue;
    logic nextValid;
    opIdT nextOpId;
    dataT nextData;
    logic toHold;

    assign fwdIssue = loadIssue.valid && loadIssue.fwdHit;
    assign memIssue = loadIssue.valid && !loadIssue.fwdHit;

    always_comb begin
        anyFree = 1'b0;
        freeTag = '0;
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
            if (!tagBusy[i]) begin
                anyFree = 1'b1;
                freeTag = tagT'(i);     // Lowest free tag ends up chosen
            end
        end
    end

    assign loadReady = !reqValid && anyFree && !holdValid;

    // Forwarded load first, then a parked response, then a fresh one
    always_comb begin
        nextValid = 1'b1;
        nextOpId = loadIssue.opId;
        nextData = loadIssue.fwdData;
        toHold = memRes.valid && (fwdIssue || holdValid);
        if (!fwdIssue) begin
            if (holdValid) begin
                nextOpId = holdOpId;
                nextData = holdData;
            end else begin
                nextValid = memRes.valid;
                nextOpId = tagOpId[memRes.tag];
                nextData = memRes.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tagBusy <= '0;
            reqValid <= 1'b0;
            holdValid <= 1'b0;
            resValid <= 1'b0;
        end else begin
            if (memRes.valid) begin
                tagBusy[memRes.tag] <= 1'b0;
            end
            if (memIssue) begin
                tagBusy[freeTag] <= 1'b1;
                reqValid <= 1'b1;
            end else if (ldGrant) begin
                reqValid <= 1'b0;
            end
            holdValid <= toHold;
            resValid <= nextValid;
        end
    end

    always_ff @(posedge clk) begin
        if (memIssue) begin
            tagOpId[freeTag] <= loadIssue.opId;
            reqAddr <= loadIssue.addr;
            reqTag <= freeTag;
        end
        if (toHold) begin
            holdOpId <= tagOpId[memRes.tag];
            holdData <= memRes.data;
        end
        resOpId <= nextOpId;
        resData <= nextData;
    end

    always_comb begin
        ldReq.valid = reqValid;
        ldReq.write = 1'b0;
        ldReq.addr = reqAddr;
        ldReq.data = '0;
        ldReq.tag = reqTag;
    end

    always_comb begin
        loadResult.valid = resValid;
        loadResult.opId = resOpId;
        loadResult.data = resData;
    end

endmodule

// ==== memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter #(
    parameter int CREDITS = 2
) (
    input logic clk,
    input logic reset,

    input lsuPkg::memReqT ldReq,
    input lsuPkg::memReqT stReq,
    output logic ldGrant,
    output logic stGrant,

    output lsuPkg::memReqT memReq,
    input logic memCredit
);
    import lsuPkg::*;

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] creditCnt;
    logic haveCredit;
    logic granted;
    memReqT selReq;

    assign haveCredit = (creditCnt != '0);

    // Loads go first so a waiting load is never passed by a younger store
    assign ldGrant = ldReq.valid && haveCredit;
    assign stGrant = stReq.valid && haveCredit && !ldReq.valid;
    assign granted = ldGrant || stGrant;

    assign selReq = ldReq.valid ? ldReq : stReq;

    always_comb begin
        memReq = selReq;
        memReq.valid = granted;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            creditCnt <= CNT_W'(CREDITS);
        end else begin
            creditCnt <= creditCnt - CNT_W'(granted) + CNT_W'(memCredit);
        end
    end

endmodule

// ==== loadStoreCore.sv ====
`timescale 1ns/1ps

module loadStoreCore #(
    parameter int OP_DEPTH = 4,
    parameter int SQ_DEPTH = 4,
    parameter int MEM_CREDITS = 2
) (
    input logic clk,
    input logic reset,

    input lsuPkg::memOpT opIn,
    output logic opCredit,

    output lsuPkg::memReqT memReq,
    input logic memCredit,
    input lsuPkg::memResT memRes,

    output lsuPkg::loadResultT loadResult
);
    import lsuPkg::*;

    memOpT fifoHead;
    logic fifoPop;

    logic loadReady;
    loadIssueT loadIssue;

    memReqT stReq;
    memReqT ldReq;
    logic stGrant;
    logic ldGrant;

    lsuFifo #(.DEPTH(OP_DEPTH)) opFifo (
        .clk(clk),
        .reset(reset),
        .opIn(opIn),
        .opCredit(opCredit),
        .head(fifoHead),
        .pop(fifoPop)
    );

    // Stores and loads leave the input queue here in program order
    storeQueue #(.DEPTH(SQ_DEPTH)) sq (
        .clk(clk),
        .reset(reset),
        .head(fifoHead),
        .pop(fifoPop),
        .loadReady(loadReady),
        .loadIssue(loadIssue),
        .stReq(stReq),
        .stGrant(stGrant)
    );

    loadUnit ldUnit (
        .clk(clk),
        .reset(reset),
        .loadIssue(loadIssue),
        .loadReady(loadReady),
        .ldReq(ldReq),
        .ldGrant(ldGrant),
        .memRes(memRes),
        .loadResult(loadResult)
    );

    memArbiter #(.CREDITS(MEM_CREDITS)) arb (
        .clk(clk),
        .reset(reset),
        .ldReq(ldReq),
        .stReq(stReq),
        .ldGrant(ldGrant),
        .stGrant(stGrant),
        .memReq(memReq),
        .memCredit(memCredit)
    );

endmodule

// ==== memModel.sv ====
`timescale 1ns/1ps

module memModel (
    input logic clk,
    input logic reset,

    input lsuPkg::memReqT memReq,
    output logic memCredit,
    output lsuPkg::memResT memRes
);
    import lsuPkg::*;

    dataT mem [2**ADDR_W];
    memReqT reqQueue [$];
    int delay;
    integer seed;

    initial begin
        seed = 20320;
        delay = 0;
        memCredit = 1'b0;
        memRes = '0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            mem[a] = ~DATA_W'(a);   // Inverse of the zero-extended address
        end
    end

    // A request counts as taken at the edge where the arbiter grants it
    always @(posedge clk) begin
        if (reset) begin
            reqQueue.delete();
            delay = 0;
        end else if (memReq.valid === 1'b1) begin
            reqQueue.push_back(memReq);
        end
    end

    // Served strictly in order, so writes and reads reach memory as granted
    always @(negedge clk) begin
        memReqT req;
        memCredit = 1'b0;
        memRes = '0;
        if (reqQueue.size() > 0) begin
            if (delay > 0) begin
                delay--;
            end else begin
                req = reqQueue.pop_front();
                if (req.write) begin
                    mem[req.addr] = req.data;
                end else begin
                    memRes.valid = 1'b1;
                    memRes.tag = req.tag;
                    memRes.data = mem[req.addr];
                end
                memCredit = 1'b1;
                delay = $unsigned($random(seed)) % 5;  // Next entry and its credit wait a while
            end
        end
    end

endmodule

// ==== loadStoreCore_checker.sv ====
`timescale 1ns/1ps

module arbiterChecker #(
    parameter int CREDITS = 2
) (
    input logic clk,
    input logic reset,
    input lsuPkg::memReqT ldReq,
    input lsuPkg::memReqT stReq,
    input logic ldGrant,
    input logic stGrant,
    input lsuPkg::memReqT memReq,
    input logic memCredit,
    input logic [$clog2(CREDITS + 1)-1:0] creditCnt
);
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] freeCredits;   // Credits as seen from the memory side

    always_ff @(posedge clk) begin
        if (reset) begin
            freeCredits <= CNT_W'(CREDITS);
        end else begin
            freeCredits <= freeCredits - CNT_W'(memReq.valid) + CNT_W'(memCredit);
        end
    end

    grantNeedsCredit: assert property (@(posedge clk) disable iff (reset)
        memReq.valid |-> (freeCredits != '0))
        else $error("Memory request sent with no credit left");

    creditBounded: assert property (@(posedge clk) disable iff (reset)
        creditCnt <= CNT_W'(CREDITS))
        else $error("Credit count rose above the number of memory credits");

    singleGrant: assert property (@(posedge clk) disable iff (reset)
        !(ldGrant && stGrant))
        else $error("Load and store granted in the same cycle");

    // A waiting request may not change until it is granted
    ldReqHeld: assert property (@(posedge clk) disable iff (reset)
        (ldReq.valid && !ldGrant) |=> (ldReq.valid && $stable(ldReq)))
        else $error("Load request changed or dropped before its grant");

    stReqHeld: assert property (@(posedge clk) disable iff (reset)
        (stReq.valid && !stGrant) |=> (stReq.valid && $stable(stReq)))
        else $error("Store request changed or dropped before its grant");

endmodule

bind memArbiter arbiterChecker #(.CREDITS(CREDITS)) arbCheck (
    .clk(clk),
    .reset(reset),
    .ldReq(ldReq),
    .stReq(stReq),
    .ldGrant(ldGrant),
    .stGrant(stGrant),
    .memReq(memReq),
    .memCredit(memCredit),
    .creditCnt(creditCnt)
);

// ==== loadStoreCore_tb.sv ====
`timescale 1ns/1ps

module loadStoreCore_tb;
    import lsuPkg::*;

    localparam int OP_DEPTH = 4;
    localparam int RANDOM_OPS = 300;
    localparam int TOTAL_OPS = RANDOM_OPS + 12;
    localparam int PERIOD = 20;
    localparam int TIME_LIMIT = (TOTAL_OPS * 40 + 300) * PERIOD;

    logic clk;
    logic reset;
    memOpT opIn;
    logic opCredit;
    memReqT memReq;
    logic memCredit;
    memResT memRes;
    loadResultT loadResult;

    memOpT history [$];    // Every operation sent, in program order
    dataT expData [2**ID_W];
    logic pending [2**ID_W];
    int pendingCnt;
    int sentCnt;
    int returnedCnt;
    int checkedCnt;
    int errors;
    integer seed;

    loadStoreCore #(
        .OP_DEPTH(OP_DEPTH),
        .SQ_DEPTH(4),
        .MEM_CREDITS(2)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .opIn(opIn),
        .opCredit(opCredit),
        .memReq(memReq),
        .memCredit(memCredit),
        .memRes(memRes),
        .loadResult(loadResult)
    );

    memModel memory (
        .clk(clk),
        .reset(reset),
        .memReq(memReq),
        .memCredit(memCredit),
        .memRes(memRes)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Replays all operations before idx over a fresh memory, then reads the load's word
    function automatic dataT refLoad(input int idx);
        dataT model [2**ADDR_W];
        for (int a = 0; a < 2**ADDR_W; a++) begin
            model[a] = ~DATA_W'(a);
        end
        for (int i = 0; i < idx; i++) begin
            if (history[i].isStore) begin
                model[history[i].addr] = history[i].data;
            end
        end
        return model[history[idx].addr];
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // Spends one input credit, waiting at falling edges until one is free
    task automatic sendOp(input logic isStore, input addrT addr, input dataT data);
        memOpT op;
        while (sentCnt - returnedCnt >= OP_DEPTH) begin
            @(negedge clk);
        end
        op.valid = 1'b1;
        op.isStore = isStore;
        op.addr = addr;
        op.data = data;
        op.opId = opIdT'(sentCnt);
        history.push_back(op);
        if (!isStore) begin
            expData[op.opId] = refLoad(history.size() - 1);
            pending[op.opId] = 1'b1;
            pendingCnt++;
        end
        opIn = op;
        sentCnt++;
        @(negedge clk);
        opIn = '0;
    endtask

    always @(posedge clk) begin
        if (!reset && opCredit === 1'b1) begin
            assert (returnedCnt < sentCnt) else begin
                $display("Input credit returned with no operation outstanding");
                errors++;
            end
            returnedCnt++;
        end
    end

    // Results come from registers, so the edge sees the value of the cycle before
    always @(posedge clk) begin
        if (!reset && loadResult.valid === 1'b1) begin
            checkedCnt++;
            assert (pending[loadResult.opId]) else begin
                $display("Result with opId %0d was never expected or came twice",
                         loadResult.opId);
                errors++;
            end
            if (pending[loadResult.opId]) begin
                assert (loadResult.data === expData[loadResult.opId]) else begin
                    $display("Fail loadResult.data (opId %h): got %h, expected %h",
                             loadResult.opId, loadResult.data, expData[loadResult.opId]);
                    errors++;
                end
                pending[loadResult.opId] = 1'b0;
                pendingCnt--;
            end
        end
    end

    initial begin
        #(TIME_LIMIT);
        $display("Timeout after %0d ns, %0d loads never returned, %0d errors",
                 TIME_LIMIT, pendingCnt, errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed = 20320;
        reset = 1'b1;
        opIn = '0;
        sentCnt = 0;
        returnedCnt = 0;
        checkedCnt = 0;
        pendingCnt = 0;
        errors = 0;
        for (int i = 0; i < 2**ID_W; i++) begin
            pending[i] = 1'b0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;

        repeat (10) begin
            @(negedge clk);
            assert (memReq.valid === 1'b0 && loadResult.valid === 1'b0 && opCredit === 1'b0)
            else begin
                $display("Output became active with no operation sent");
                errors++;
            end
        end

        for (int a = 'h80; a < 'h84; a++) begin
            sendOp(1'b0, addrT'(a), '0);    // Never written
        end
        sendOp(1'b1, 8'h40, 32'h1111_1111);
        sendOp(1'b0, 8'h40, '0);
        sendOp(1'b1, 8'h41, 32'hAAAA_0001);
        sendOp(1'b1, 8'h41, 32'hAAAA_0002);
        sendOp(1'b1, 8'h41, 32'hAAAA_0003);
        sendOp(1'b0, 8'h41, '0);    // Youngest of the three stores wins
        sendOp(1'b1, 8'h50, 32'h5555_AAAA);
        idle(40);   // Store has long since drained to memory
        sendOp(1'b0, 8'h50, '0);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            sendOp(1'($random(seed)), addrT'($unsigned($random(seed)) % 16), $random(seed));
            if ($unsigned($random(seed)) % 8 == 0) begin
                idle($unsigned($random(seed)) % 4);
            end
        end

        wait (pendingCnt == 0);
        idle(50);
        assert (returnedCnt == sentCnt) else begin
            $display("Only %0d of %0d input credits came back", returnedCnt, sentCnt);
            errors++;
        end
        $display("%0d loads checked, %0d errors", checkedCnt, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== loadStoreCore.f ====
lsuPkg.sv
lsuFifo.sv
storeQueue.sv
loadUnit.sv
memArbiter.sv
loadStoreCore.sv
memModel.sv
loadStoreCore_checker.sv
loadStoreCore_tb.sv

// ==== Makefile ====
SRCS := $(shell cat loadStoreCore.f)

run: obj_dir/VloadStoreCore_tb
	./obj_dir/VloadStoreCore_tb | tee /dev/stderr | grep -qx "No errors"

obj_dir/VloadStoreCore_tb: loadStoreCore.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module loadStoreCore_tb -f loadStoreCore.f

clean:
	rm -rf obj_dir

.PHONY: run clean
